//--- cache_pkg.sv
package cache_pkg;

  // ================================================
  // Widths shared by the processor and AXI sides
  // ================================================

  // Byte address, both sides
  localparam int ADDR_W = 32;

  // One cache word, also one AXI beat
  localparam int WORD_W = 32;

  // Byte lanes per word
  localparam int STRB_W = WORD_W / 8;

  // All lanes set means the write covers the whole word
  localparam logic [STRB_W-1:0] FULL_STRB = '1;

  // ================================================
  // Controller states
  // ================================================
  typedef enum logic [1:0] {
    IDLE,
    FILL,
    WRITE
  } ctrl_state_t;

  // ================================================
  // AXI channel payloads
  // ================================================

  // AR, line aligned, len is beats minus one
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } axi_ar_t;

  // R beat, id and resp are not carried
  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic              last;
  } axi_r_t;

  // AW, single beat
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
  } axi_aw_t;

  // W beat, last is implied
  typedef struct packed {
    logic [WORD_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } axi_w_t;

  // ================================================
  // Processor write request
  // ================================================
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } cpu_wr_t;

endpackage

//--- cache_ctrl_fsm.sv
`timescale 1ns/1ps

module cache_ctrl_fsm (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_rd_valid,
  input  logic                   i_rd_hit,
  input  logic                   i_wr_valid,
  input  logic                   i_r_valid,
  input  logic                   i_r_last,
  input  logic                   i_ar_ready,
  input  logic                   i_aw_ready,
  input  logic                   i_w_ready,
  output cache_pkg::ctrl_state_t o_state,
  output logic                   o_rd_ready,
  output logic                   o_wr_ready,
  output logic                   o_fill_start,
  output logic                   o_fill_done,
  output logic                   o_wt_start,
  output logic                   o_ar_valid,
  output logic                   o_aw_valid,
  output logic                   o_w_valid
);

  cache_pkg::ctrl_state_t state_q;
  cache_pkg::ctrl_state_t state_d;

  // Sticky completion flags for the write-through
  logic aw_done_q;
  logic w_done_q;

  logic aw_fire;
  logic w_fire;
  logic aw_complete;
  logic w_complete;

  // ================================================
  // Write channel tracking
  // ================================================
  assign aw_fire = o_aw_valid && i_aw_ready;
  assign w_fire  = o_w_valid && i_w_ready;

  // Done if seen earlier or completing right now
  assign aw_complete = aw_done_q || aw_fire;
  assign w_complete  = w_done_q || w_fire;

  // ================================================
  // Next state and event strobes
  // ================================================
  always_comb begin
    state_d      = state_q;
    o_fill_start = 1'b0;
    o_wt_start   = 1'b0;
    o_fill_done  = 1'b0;
    o_wr_ready   = 1'b0;

    case (state_q)
      cache_pkg::IDLE: begin
        // Read hits are answered in place, a miss goes off to fill
        if (i_rd_valid && !i_rd_hit) begin
          o_fill_start = 1'b1;
          state_d      = cache_pkg::FILL;
        end else if (i_wr_valid) begin
          o_wt_start = 1'b1;
          state_d    = cache_pkg::WRITE;
        end
      end

      cache_pkg::FILL: begin
        // R ready is tied high, so every valid beat is taken
        if (i_r_valid && i_r_last) begin
          o_fill_done = 1'b1;
          state_d     = cache_pkg::IDLE;
        end
      end

      cache_pkg::WRITE: begin
        // Processor write transfers once both AW and W are through
        if (aw_complete && w_complete) begin
          o_wr_ready = 1'b1;
          state_d    = cache_pkg::IDLE;
        end
      end

      default: begin
        state_d = cache_pkg::IDLE;
      end
    endcase
  end

  // Reads only get in while idle
  assign o_rd_ready = (state_q == cache_pkg::IDLE);
  assign o_state    = state_q;

  // ================================================
  // State and AXI valid registers
  // ================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q    <= cache_pkg::IDLE;
      o_ar_valid <= 1'b0;
      o_aw_valid <= 1'b0;
      o_w_valid  <= 1'b0;
      aw_done_q  <= 1'b0;
      w_done_q   <= 1'b0;
    end else begin
      state_q <= state_d;

      // Raise one cycle after the event, drop on handshake
      o_ar_valid <= o_fill_start || (o_ar_valid && !i_ar_ready);
      o_aw_valid <= o_wt_start || (o_aw_valid && !i_aw_ready);
      o_w_valid  <= o_wt_start || (o_w_valid && !i_w_ready);

      // Cleared when a new write-through begins
      aw_done_q <= !o_wt_start && aw_complete;
      w_done_q  <= !o_wt_start && w_complete;
    end
  end

  // ================================================
  // Checks
  // ================================================

  // AR stays up until memory takes it, all within the fill
  a_ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
    o_ar_valid && !i_ar_ready |=> o_ar_valid && (state_q == cache_pkg::FILL));

  // Busy states never carry the other request's channels
  a_busy_no_accept : assert property (@(posedge clk) disable iff (!rst_n)
    !((state_q == cache_pkg::FILL) && (o_aw_valid || o_w_valid)) &&
    !((state_q == cache_pkg::WRITE) && o_ar_valid));

endmodule

//--- fill_beat_counter.sv
`timescale 1ns/1ps

module fill_beat_counter #(
  parameter int CACHE_BYTES = 1024,
  parameter int LINE_BYTES  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         i_fill_start,
  input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
  input  logic                         i_r_valid,
  output logic [$clog2(LINE_BYTES/4)-1:0] o_word_idx,
  output logic [$clog2(CACHE_BYTES/LINE_BYTES)-1:0] o_set,
  output logic [cache_pkg::ADDR_W-$clog2(CACHE_BYTES)-1:0] o_tag,
  output logic                         o_beat_is_req
);

  // Line geometry
  localparam int SETS  = CACHE_BYTES / LINE_BYTES;
  localparam int WORDS = LINE_BYTES / 4;
  localparam int OFF_W = $clog2(LINE_BYTES);
  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = cache_pkg::ADDR_W - SET_W - OFF_W;
  localparam int IDX_W = $clog2(WORDS);

  // One extra bit so a full line is visible
  logic [IDX_W:0]   beat_cnt_q;
  logic [IDX_W-1:0] req_off_q;

  // Beat counter, restarts with every miss
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      beat_cnt_q <= '0;
    end else if (i_fill_start) begin
      beat_cnt_q <= '0;
    end else if (i_r_valid) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // Miss address held for the whole fill
  always_ff @(posedge clk) begin
    if (i_fill_start) begin
      o_tag     <= i_rd_addr[cache_pkg::ADDR_W-1 -: TAG_W];
      o_set     <= i_rd_addr[OFF_W +: SET_W];
      req_off_q <= i_rd_addr[2 +: IDX_W];
    end
  end

  // Incrementing burst, so beat number is the word index
  assign o_word_idx = beat_cnt_q[IDX_W-1:0];

  // Live beat carries the word the processor asked for
  assign o_beat_is_req = i_r_valid && (o_word_idx == req_off_q);

  // Memory never sends more beats than the line holds
  a_beat_in_line : assert property (@(posedge clk) disable iff (!rst_n)
    i_r_valid |-> (beat_cnt_q < (IDX_W + 1)'(WORDS)));

endmodule

//--- cache_tag_store.sv
`timescale 1ns/1ps

module cache_tag_store #(
  parameter int CACHE_BYTES = 1024,
  parameter int LINE_BYTES  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
  input  cache_pkg::cpu_wr_t           i_wr,
  input  logic                         i_wr_accept,
  input  logic                         i_fill_done,
  input  logic [$clog2(CACHE_BYTES/LINE_BYTES)-1:0] i_fill_set,
  input  logic [cache_pkg::ADDR_W-$clog2(CACHE_BYTES)-1:0] i_fill_tag,
  output logic                         o_rd_hit,
  output logic                         o_wr_hit
);

  localparam int SETS  = CACHE_BYTES / LINE_BYTES;
  localparam int OFF_W = $clog2(LINE_BYTES);
  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = cache_pkg::ADDR_W - SET_W - OFF_W;

  // One tag and one valid bit per set
  logic [TAG_W-1:0] tag_mem [SETS];
  logic [SETS-1:0]  valid_q;

  logic [SET_W-1:0] rd_set;
  logic [TAG_W-1:0] rd_tag;
  logic [SET_W-1:0] wr_set;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_partial_hit;

  // ================================================
  // Lookup
  // ================================================
  assign rd_set = i_rd_addr[OFF_W +: SET_W];
  assign rd_tag = i_rd_addr[cache_pkg::ADDR_W-1 -: TAG_W];
  assign wr_set = i_wr.addr[OFF_W +: SET_W];
  assign wr_tag = i_wr.addr[cache_pkg::ADDR_W-1 -: TAG_W];

  assign o_rd_hit = valid_q[rd_set] && (tag_mem[rd_set] == rd_tag);
  assign o_wr_hit = valid_q[wr_set] && (tag_mem[wr_set] == wr_tag);

  // Partial word cannot be merged in place, drop the line
  assign wr_partial_hit = i_wr_accept && o_wr_hit &&
                          (i_wr.strb != cache_pkg::FULL_STRB);

  // ================================================
  // Valid table
  // ================================================
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (i_fill_done) begin
      valid_q[i_fill_set] <= 1'b1;
    end else if (wr_partial_hit) begin
      valid_q[wr_set] <= 1'b0;
    end
  end

  // Tag written with the last fill beat
  always_ff @(posedge clk) begin
    if (i_fill_done) begin
      tag_mem[i_fill_set] <= i_fill_tag;
    end
  end

endmodule

//--- cache_data_store.sv
`timescale 1ns/1ps

module cache_data_store #(
  parameter int CACHE_BYTES = 1024,
  parameter int LINE_BYTES  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
  input  logic                         i_rd_accept_hit,
  input  logic                         i_fill_done,
  input  logic                         i_r_valid,
  input  cache_pkg::axi_r_t            i_r,
  input  logic [$clog2(CACHE_BYTES/LINE_BYTES)-1:0] i_fill_set,
  input  logic [$clog2(LINE_BYTES/4)-1:0] i_word_idx,
  input  logic                         i_beat_is_req,
  input  cache_pkg::cpu_wr_t           i_wr,
  input  logic                         i_wr_full_hit,
  output logic [cache_pkg::WORD_W-1:0] o_rd_data,
  output logic                         o_rd_valid
);

  localparam int SETS  = CACHE_BYTES / LINE_BYTES;
  localparam int WORDS = LINE_BYTES / 4;
  localparam int OFF_W = $clog2(LINE_BYTES);
  localparam int SET_W = $clog2(SETS);
  localparam int IDX_W = $clog2(WORDS);
  localparam int DEPTH = SETS * WORDS;

  // Flat word array, set in the upper index bits
  logic [cache_pkg::WORD_W-1:0] data_mem [DEPTH];

  logic                         wr_en;
  logic [SET_W+IDX_W-1:0]       wr_index;
  logic [cache_pkg::WORD_W-1:0] wr_word;
  logic [cache_pkg::WORD_W-1:0] hit_word;
  logic [cache_pkg::WORD_W-1:0] fill_word_q;
  logic [cache_pkg::WORD_W-1:0] fill_word;

  // ================================================
  // Single write port
  // ================================================
  always_comb begin
    wr_en    = 1'b0;
    wr_index = '0;
    wr_word  = '0;
    // Fill beats first
    if (i_r_valid) begin
      wr_en    = 1'b1;
      wr_index = {i_fill_set, i_word_idx};
      wr_word  = i_r.data;
    end else if (i_wr_full_hit) begin
      wr_en    = 1'b1;
      wr_index = {i_wr.addr[OFF_W +: SET_W], i_wr.addr[2 +: IDX_W]};
      wr_word  = i_wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_mem[wr_index] <= wr_word;
    end
  end

  // Word under the read address
  assign hit_word = data_mem[{i_rd_addr[OFF_W +: SET_W], i_rd_addr[2 +: IDX_W]}];

  // ================================================
  // Fill word capture
  // ================================================
  always_ff @(posedge clk) begin
    if (i_beat_is_req) begin
      fill_word_q <= i_r.data;
    end
  end

  // Requested word may sit on the closing beat itself
  assign fill_word = i_beat_is_req ? i_r.data : fill_word_q;

  // ================================================
  // Response register
  // ================================================
  always_ff @(posedge clk) begin
    if (i_rd_accept_hit || i_fill_done) begin
      o_rd_data <= i_fill_done ? fill_word : hit_word;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      o_rd_valid <= 1'b0;
    end else begin
      o_rd_valid <= i_rd_accept_hit || i_fill_done;
    end
  end

endmodule

//--- wt_cache_top.sv
`timescale 1ns/1ps

module wt_cache_top #(
  parameter int CACHE_BYTES = 1024,
  parameter int LINE_BYTES  = 16
) (
  input  logic                         clk,
  input  logic                         rst_n,
  // Processor read port
  input  logic                         i_rd_valid,
  input  logic [cache_pkg::ADDR_W-1:0] i_rd_addr,
  output logic                         o_rd_ready,
  output logic [cache_pkg::WORD_W-1:0] o_rd_data,
  output logic                         o_rd_valid,
  // Processor write port
  input  logic                         i_wr_valid,
  input  cache_pkg::cpu_wr_t           i_wr,
  output logic                         o_wr_ready,
  // AXI read channels
  output logic                         o_ar_valid,
  output cache_pkg::axi_ar_t           o_ar,
  input  logic                         i_ar_ready,
  input  logic                         i_r_valid,
  input  cache_pkg::axi_r_t            i_r,
  output logic                         o_r_ready,
  // AXI write channels
  output logic                         o_aw_valid,
  output cache_pkg::axi_aw_t           o_aw,
  input  logic                         i_aw_ready,
  output logic                         o_w_valid,
  output cache_pkg::axi_w_t            o_w,
  input  logic                         i_w_ready,
  input  logic                         i_b_valid,
  output logic                         o_b_ready
);

  localparam int SETS  = CACHE_BYTES / LINE_BYTES;
  localparam int WORDS = LINE_BYTES / 4;
  localparam int OFF_W = $clog2(LINE_BYTES);
  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = cache_pkg::ADDR_W - SET_W - OFF_W;
  localparam int IDX_W = $clog2(WORDS);

  cache_pkg::ctrl_state_t state;

  logic             rd_hit;
  logic             wr_hit;
  logic             fill_start;
  logic             fill_done;
  logic             wt_start;
  logic             beat_is_req;
  logic             rd_accept_hit;
  logic             wr_full_hit;
  logic [IDX_W-1:0] word_idx;
  logic [SET_W-1:0] fill_set;
  logic [TAG_W-1:0] fill_tag;

  // ================================================
  // Glue
  // ================================================

  // Read hit taken straight from idle
  assign rd_accept_hit = (state == cache_pkg::IDLE) && i_rd_valid && rd_hit;

  // Whole-word write hit updates the array in place
  assign wr_full_hit = wt_start && wr_hit && (i_wr.strb == cache_pkg::FULL_STRB);

  // Line-aligned fill address from the captured miss fields
  assign o_ar.addr = {fill_tag, fill_set, {OFF_W{1'b0}}};
  assign o_ar.len  = 8'(WORDS - 1);

  // Processor holds the write stable until o_wr_ready
  assign o_aw.addr = i_wr.addr;
  assign o_w.data  = i_wr.data;
  assign o_w.strb  = i_wr.strb;

  // R and B are always accepted; B is not inspected
  assign o_r_ready = 1'b1;
  assign o_b_ready = 1'b1;

  // ================================================
  // Submodules
  // ================================================
  cache_ctrl_fsm u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_rd_valid   (i_rd_valid),
    .i_rd_hit     (rd_hit),
    .i_wr_valid   (i_wr_valid),
    .i_r_valid    (i_r_valid),
    .i_r_last     (i_r.last),
    .i_ar_ready   (i_ar_ready),
    .i_aw_ready   (i_aw_ready),
    .i_w_ready    (i_w_ready),
    .o_state      (state),
    .o_rd_ready   (o_rd_ready),
    .o_wr_ready   (o_wr_ready),
    .o_fill_start (fill_start),
    .o_fill_done  (fill_done),
    .o_wt_start   (wt_start),
    .o_ar_valid   (o_ar_valid),
    .o_aw_valid   (o_aw_valid),
    .o_w_valid    (o_w_valid)
  );

  fill_beat_counter #(
    .CACHE_BYTES (CACHE_BYTES),
    .LINE_BYTES  (LINE_BYTES)
  ) u_beats (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_fill_start  (fill_start),
    .i_rd_addr     (i_rd_addr),
    .i_r_valid     (i_r_valid),
    .o_word_idx    (word_idx),
    .o_set         (fill_set),
    .o_tag         (fill_tag),
    .o_beat_is_req (beat_is_req)
  );

  cache_tag_store #(
    .CACHE_BYTES (CACHE_BYTES),
    .LINE_BYTES  (LINE_BYTES)
  ) u_tags (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_rd_addr   (i_rd_addr),
    .i_wr        (i_wr),
    .i_wr_accept (wt_start),
    .i_fill_done (fill_done),
    .i_fill_set  (fill_set),
    .i_fill_tag  (fill_tag),
    .o_rd_hit    (rd_hit),
    .o_wr_hit    (wr_hit)
  );

  cache_data_store #(
    .CACHE_BYTES (CACHE_BYTES),
    .LINE_BYTES  (LINE_BYTES)
  ) u_data (
    .clk             (clk),
    .rst_n           (rst_n),
    .i_rd_addr       (i_rd_addr),
    .i_rd_accept_hit (rd_accept_hit),
    .i_fill_done     (fill_done),
    .i_r_valid       (i_r_valid),
    .i_r             (i_r),
    .i_fill_set      (fill_set),
    .i_word_idx      (word_idx),
    .i_beat_is_req   (beat_is_req),
    .i_wr            (i_wr),
    .i_wr_full_hit   (wr_full_hit),
    .o_rd_data       (o_rd_data),
    .o_rd_valid      (o_rd_valid)
  );

endmodule

//--- tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen (
  output logic o_clk,
  output logic o_rst_n
);

  // 20 ns period
  initial begin
    o_clk = 1'b0;
    forever begin
      #10 o_clk = ~o_clk;
    end
  end

  // Reset held low for the first 5 rising edges
  initial begin
    o_rst_n = 1'b0;
    repeat (5) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule

//--- tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
  input  logic                         clk,
  input  logic                         rst_n,
  // Operation framing from the driver
  input  logic                         i_op_start,
  input  logic                         i_op_done,
  input  logic                         i_op_is_rd,
  input  logic [cache_pkg::ADDR_W-1:0] i_op_addr,
  input  logic [cache_pkg::WORD_W-1:0] i_exp_data,
  input  logic                         i_exp_burst,
  // DUT ports under watch
  input  logic                         i_ar_valid,
  input  logic                         i_ar_ready,
  input  cache_pkg::axi_ar_t           i_ar,
  input  logic                         i_r_ready,
  input  logic                         i_b_ready,
  input  logic                         i_rd_valid,
  input  logic [cache_pkg::WORD_W-1:0] i_rd_data,
  output int                           o_pass_cnt,
  output int                           o_fail_cnt
);

  int                           op_num;
  int                           ar_cnt;
  int                           rd_cnt;
  logic [cache_pkg::ADDR_W-1:0] ar_addr;
  logic [7:0]                   ar_len;
  logic [cache_pkg::WORD_W-1:0] rd_data;
  logic [cache_pkg::ADDR_W-1:0] line_addr;
  logic                         r_ready_low;
  logic                         b_ready_low;
  logic                         bad;

  initial begin
    o_pass_cnt  = 0;
    o_fail_cnt  = 0;
    op_num      = 0;
    ar_cnt      = 0;
    rd_cnt      = 0;
    ar_addr     = '0;
    ar_len      = '0;
    rd_data     = '0;
    r_ready_low = 1'b0;
    b_ready_low = 1'b0;
  end

  always @(posedge clk) begin
    if (rst_n) begin
      // New operation clears the per-op tallies
      if (i_op_start) begin
        ar_cnt      = 0;
        rd_cnt      = 0;
        r_ready_low = 1'b0;
        b_ready_low = 1'b0;
      end
      // AR handshakes seen during this operation
      if (i_ar_valid && i_ar_ready) begin
        ar_cnt  = ar_cnt + 1;
        ar_addr = i_ar.addr;
        ar_len  = i_ar.len;
      end
      if (i_rd_valid) begin
        rd_cnt  = rd_cnt + 1;
        rd_data = i_rd_data;
      end
      // R and B must always be accepted
      if (!i_r_ready) begin
        r_ready_low = 1'b1;
      end
      if (!i_b_ready) begin
        b_ready_low = 1'b1;
      end

      // ================================================
      // Compare at the end of each operation
      // ================================================
      if (i_op_done) begin
        bad       = 1'b0;
        // 16-byte lines
        line_addr = {i_op_addr[cache_pkg::ADDR_W-1:4], 4'h0};
        if (ar_cnt != (i_exp_burst ? 1 : 0)) begin
          $display("FAIL op %0d o_ar_valid handshakes got %h exp %h", op_num, ar_cnt,
                   i_exp_burst ? 1 : 0);
          bad = 1'b1;
        end else if (i_exp_burst && ar_addr != line_addr) begin
          $display("FAIL op %0d o_ar.addr got %h exp %h", op_num, ar_addr, line_addr);
          bad = 1'b1;
        end else if (i_exp_burst && ar_len != 8'h03) begin
          // Four beats per line
          $display("FAIL op %0d o_ar.len got %h exp %h", op_num, ar_len, 8'h03);
          bad = 1'b1;
        end else if (r_ready_low) begin
          $display("FAIL op %0d o_r_ready got %h exp %h", op_num, 1'b0, 1'b1);
          bad = 1'b1;
        end else if (b_ready_low) begin
          $display("FAIL op %0d o_b_ready got %h exp %h", op_num, 1'b0, 1'b1);
          bad = 1'b1;
        end
        if (i_op_is_rd) begin
          if (rd_cnt != 1) begin
            $display("op %0d: expected one read response but saw %0d", op_num, rd_cnt);
            bad = 1'b1;
          end else if (rd_data != i_exp_data) begin
            $display("FAIL op %0d o_rd_data got %h exp %h", op_num, rd_data, i_exp_data);
            bad = 1'b1;
          end
        end else if (rd_cnt != 0) begin
          $display("op %0d: read response appeared during a write", op_num);
          bad = 1'b1;
        end
        // Per-op result line
        if (bad) begin
          o_fail_cnt = o_fail_cnt + 1;
        end else begin
          o_pass_cnt = o_pass_cnt + 1;
          $display("ok   op %0d %s addr %h", op_num, i_op_is_rd ? "R" : "W", i_op_addr);
        end
        op_num = op_num + 1;
      end
    end
  end

endmodule

//--- tb_cache.sv
`timescale 1ns/1ps

module tb_cache;

  localparam int MAX_OPS   = 64;
  localparam int MEM_WORDS = 1024;

  logic clk;
  logic rst_n;

  // DUT ports
  logic                         i_rd_valid;
  logic [cache_pkg::ADDR_W-1:0] i_rd_addr;
  logic                         o_rd_ready;
  logic [cache_pkg::WORD_W-1:0] o_rd_data;
  logic                         o_rd_valid;
  logic                         i_wr_valid;
  cache_pkg::cpu_wr_t           i_wr;
  logic                         o_wr_ready;
  logic                         o_ar_valid;
  cache_pkg::axi_ar_t           o_ar;
  logic                         i_ar_ready;
  logic                         i_r_valid;
  cache_pkg::axi_r_t            i_r;
  logic                         o_r_ready;
  logic                         o_aw_valid;
  cache_pkg::axi_aw_t           o_aw;
  logic                         i_aw_ready;
  logic                         o_w_valid;
  cache_pkg::axi_w_t            o_w;
  logic                         i_w_ready;
  logic                         i_b_valid;
  logic                         o_b_ready;

  // Operation framing towards the checker
  logic                         op_start;
  logic                         op_done;
  logic                         op_is_rd;
  logic [cache_pkg::ADDR_W-1:0] op_addr;
  logic [cache_pkg::WORD_W-1:0] exp_data;
  logic                         exp_burst;
  int                           pass_cnt;
  int                           fail_cnt;

  // Stimulus table
  logic [7:0]                   tbl_op    [MAX_OPS];
  logic [cache_pkg::ADDR_W-1:0] tbl_addr  [MAX_OPS];
  logic [cache_pkg::WORD_W-1:0] tbl_data  [MAX_OPS];
  logic [3:0]                   tbl_strb  [MAX_OPS];
  logic [cache_pkg::WORD_W-1:0] tbl_exp   [MAX_OPS];
  logic                         tbl_burst [MAX_OPS];
  int                           n_ops;
  logic                         loaded;

  // Memory model state
  logic [31:0] mem [MEM_WORDS];
  logic [31:0] lfsr_q;
  logic [31:0] aw_addr_q;
  logic [31:0] w_data_q;
  logic [3:0]  w_strb_q;
  logic        aw_got;
  logic        w_got;

  tb_clkgen u_clkgen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  wt_cache_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_rd_valid (i_rd_valid),
    .i_rd_addr  (i_rd_addr),
    .o_rd_ready (o_rd_ready),
    .o_rd_data  (o_rd_data),
    .o_rd_valid (o_rd_valid),
    .i_wr_valid (i_wr_valid),
    .i_wr       (i_wr),
    .o_wr_ready (o_wr_ready),
    .o_ar_valid (o_ar_valid),
    .o_ar       (o_ar),
    .i_ar_ready (i_ar_ready),
    .i_r_valid  (i_r_valid),
    .i_r        (i_r),
    .o_r_ready  (o_r_ready),
    .o_aw_valid (o_aw_valid),
    .o_aw       (o_aw),
    .i_aw_ready (i_aw_ready),
    .o_w_valid  (o_w_valid),
    .o_w        (o_w),
    .i_w_ready  (i_w_ready),
    .i_b_valid  (i_b_valid),
    .o_b_ready  (o_b_ready)
  );

  tb_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_op_start  (op_start),
    .i_op_done   (op_done),
    .i_op_is_rd  (op_is_rd),
    .i_op_addr   (op_addr),
    .i_exp_data  (exp_data),
    .i_exp_burst (exp_burst),
    .i_ar_valid  (o_ar_valid),
    .i_ar_ready  (i_ar_ready),
    .i_ar        (o_ar),
    .i_r_ready   (o_r_ready),
    .i_b_ready   (o_b_ready),
    .i_rd_valid  (o_rd_valid),
    .i_rd_data   (o_rd_data),
    .o_pass_cnt  (pass_cnt),
    .o_fail_cnt  (fail_cnt)
  );

  // ================================================
  // Stall source
  // ================================================

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two bits, one LFSR step per bit
  task automatic draw_stall(output int n);
    lfsr_q = lfsr_next(lfsr_q);
    n      = int'(lfsr_q[0]);
    lfsr_q = lfsr_next(lfsr_q);
    n      = n * 2 + int'(lfsr_q[0]);
  endtask

  // ================================================
  // Memory model
  // ================================================

  // AR then the incrementing R burst
  always begin : ar_r_model
    int          stall;
    int          beats;
    logic [31:0] base;
    @(posedge clk);
    if (rst_n && o_ar_valid) begin
      draw_stall(stall);
      repeat (stall) @(posedge clk);
      i_ar_ready <= 1'b1;
      base  = o_ar.addr;
      beats = int'(o_ar.len) + 1;
      @(posedge clk);
      i_ar_ready <= 1'b0;
      for (int b = 0; b < beats; b++) begin
        i_r_valid <= 1'b0;
        draw_stall(stall);
        repeat (stall) @(posedge clk);
        i_r_valid <= 1'b1;
        i_r.data  <= mem[(base[11:2] + b) % MEM_WORDS];
        i_r.last  <= (b == beats - 1);
        @(posedge clk);
      end
      i_r_valid <= 1'b0;
      i_r.last  <= 1'b0;
    end
  end

  always begin : aw_model
    int stall;
    @(posedge clk);
    if (rst_n && o_aw_valid) begin
      draw_stall(stall);
      repeat (stall) @(posedge clk);
      i_aw_ready <= 1'b1;
      @(posedge clk);
      // Handshake edge
      i_aw_ready <= 1'b0;
      aw_addr_q = o_aw.addr;
      aw_got    = 1'b1;
    end
  end

  always begin : w_model
    int stall;
    @(posedge clk);
    if (rst_n && o_w_valid) begin
      draw_stall(stall);
      repeat (stall) @(posedge clk);
      i_w_ready <= 1'b1;
      @(posedge clk);
      i_w_ready <= 1'b0;
      w_data_q = o_w.data;
      w_strb_q = o_w.strb;
      w_got    = 1'b1;
    end
  end

  // Byte-lane merge once both halves are in, then a B pulse
  always begin : write_merge
    wait (aw_got && w_got);
    for (int l = 0; l < 4; l++) begin
      if (w_strb_q[l]) begin
        mem[aw_addr_q[11:2]][8*l +: 8] = w_data_q[8*l +: 8];
      end
    end
    aw_got = 1'b0;
    w_got  = 1'b0;
    @(posedge clk);
    i_b_valid <= 1'b1;
    @(posedge clk);
    i_b_valid <= 1'b0;
  end

  // ================================================
  // Stimulus load
  // ================================================
  task automatic load_stimulus();
    int    fd;
    int    cnt;
    string line;
    logic [7:0]  op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] s;
    logic [31:0] e;
    int          f;
    fd = $fopen("cache_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open cache_stimulus.txt");
    end else begin
      while (!$feof(fd) && n_ops < MAX_OPS) begin
        line = "";
        void'($fgets(line, fd));
        // Skip comments and blank lines
        if (line.len() > 2 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%c %h %h %h %h %d", op, a, d, s, e, f);
          if (cnt == 6) begin
            tbl_op[n_ops]    = op;
            tbl_addr[n_ops]  = a;
            tbl_data[n_ops]  = d;
            tbl_strb[n_ops]  = s[3:0];
            tbl_exp[n_ops]   = e;
            tbl_burst[n_ops] = (f != 0);
            n_ops            = n_ops + 1;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // ================================================
  // Driver
  // ================================================
  task automatic run_op(input int k);
    logic is_rd;
    is_rd = (tbl_op[k] == "R");
    op_start  <= 1'b1;
    op_is_rd  <= is_rd;
    op_addr   <= tbl_addr[k];
    exp_data  <= tbl_exp[k];
    exp_burst <= tbl_burst[k];
    if (is_rd) begin
      i_rd_valid <= 1'b1;
      i_rd_addr  <= tbl_addr[k];
    end else begin
      i_wr_valid <= 1'b1;
      i_wr.addr  <= tbl_addr[k];
      i_wr.data  <= tbl_data[k];
      i_wr.strb  <= tbl_strb[k];
    end
    // Hold the request until it transfers
    forever begin
      @(posedge clk);
      op_start <= 1'b0;
      if (is_rd && i_rd_valid && o_rd_ready) begin
        i_rd_valid <= 1'b0;
        break;
      end
      if (!is_rd && i_wr_valid && o_wr_ready) begin
        i_wr_valid <= 1'b0;
        break;
      end
    end
    // A read ends with its response pulse
    if (is_rd) begin
      while (!o_rd_valid) begin
        @(posedge clk);
      end
    end
    op_done <= 1'b1;
    @(posedge clk);
    op_done <= 1'b0;
  endtask

  initial begin
    i_rd_valid = 1'b0;
    i_rd_addr  = '0;
    i_wr_valid = 1'b0;
    i_wr       = '0;
    i_ar_ready = 1'b0;
    i_r_valid  = 1'b0;
    i_r        = '0;
    i_aw_ready = 1'b0;
    i_w_ready  = 1'b0;
    i_b_valid  = 1'b0;
    op_start   = 1'b0;
    op_done    = 1'b0;
    op_is_rd   = 1'b0;
    op_addr    = '0;
    exp_data   = '0;
    exp_burst  = 1'b0;
    lfsr_q     = 32'hcd30f71d;
    aw_got     = 1'b0;
    w_got      = 1'b0;
    n_ops      = 0;
    loaded     = 1'b0;
    // Fill pattern over the whole byte address
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = (i * 4) ^ 32'h5a5a0000;
    end
    load_stimulus();
    loaded = 1'b1;

    wait (rst_n);
    @(posedge clk);
    for (int k = 0; k < n_ops; k++) begin
      run_op(k);
    end
    @(posedge clk);
    $display("tests: %0d run, %0d passed, %0d failed", n_ops, pass_cnt, fail_cnt);
    if (fail_cnt == 0 && pass_cnt == n_ops && n_ops > 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

  // Watchdog, 200 cycles per stimulus line
  initial begin
    wait (loaded);
    #(n_ops * 200 * 20 + 1000);
    $display("watchdog expired before all operations finished");
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- cache_stimulus.txt
# op addr data strb exp_rd_data burst
# op R or W, hex fields, burst 1 when one AR fill is expected
R 00000104 00000000 0 5a5a0104 1
R 00000108 00000000 0 5a5a0108 0
W 0000010c 11223344 f 00000000 0
R 0000010c 00000000 0 11223344 0
W 00000104 aabbccdd 3 00000000 0
R 00000104 00000000 0 5a5accdd 1
R 0000010c 00000000 0 11223344 0
R 00000504 00000000 0 5a5a0504 1
R 0000010c 00000000 0 11223344 1
W 00000220 cafef00d f 00000000 0
R 00000220 00000000 0 cafef00d 1
W 00000224 12345678 c 00000000 0
R 00000224 00000000 0 12340224 1
R 000003f0 00000000 0 5a5a03f0 1
R 000003fc 00000000 0 5a5a03fc 0
R 000007fc 00000000 0 5a5a07fc 1
R 000003f8 00000000 0 5a5a03f8 1
W 000003f4 0badf00d f 00000000 0
R 000003f4 00000000 0 0badf00d 0
R 00000ff8 00000000 0 5a5a0ff8 1
R 000003f4 00000000 0 0badf00d 1
W 00000ff0 0000abcd 1 00000000 0
R 00000ff0 00000000 0 5a5a0fcd 1
R 00000500 00000000 0 5a5a0500 1
R 0000050c 00000000 0 5a5a050c 0

//--- vlog.f
cache_pkg.sv
cache_ctrl_fsm.sv
fill_beat_counter.sv
cache_tag_store.sv
cache_data_store.sv
wt_cache_top.sv
tb_clkgen.sv
tb_checker.sv
tb_cache.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache -f vlog.f -o Vtb_cache

./obj_dir/Vtb_cache | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
